//--- Makefile
TOP = tb_reindeer_core

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

//--- include/reindeer_config.svh
// width and depth macros for the core
`ifndef REINDEER_CONFIG_SVH
`define REINDEER_CONFIG_SVH

// data and instruction word
`define XLEN 32

// word memory holds 2**MEM_ADDR_BITS words
`define MEM_ADDR_BITS 8

// program counter is a byte address
`define PC_BITWIDTH (`MEM_ADDR_BITS + 2)

// register index
`define REG_ADDR_BITS 5

`endif

//--- source/core_pkg.sv
// microarchitecture types: word, addresses, memory requester, controller state
`include "reindeer_config.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]          word_t;
    typedef logic [`PC_BITWIDTH-1:0]   pc_t;
    typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;

    // owner of a memory read in flight
    typedef enum logic [1:0] {
        src_none,
        src_ocd,
        src_data,
        src_fetch
    } mem_src_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_execute,
        st_memory
    } ctl_state_t;

endpackage

//--- source/decode_execute.sv
// instruction decode, alu, next pc and load/store address
`timescale 1ns/1ns
`include "reindeer_config.svh"

module decode_execute (
    input  logic                exec_valid_i,
    input  core_pkg::word_t     instr_i,
    input  core_pkg::pc_t       pc_i,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output logic                rd_we_o,
    output core_pkg::reg_addr_t rd_addr_o,
    output core_pkg::word_t     rd_data_o,
    output core_pkg::pc_t       next_pc_o,
    output logic                load_o,
    output logic                store_o,
    output core_pkg::mem_addr_t ls_addr_o,
    output core_pkg::word_t     store_data_o,
    output logic                halt_o
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::alu_op_t alu_op;
    logic [6:0]          funct7;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_s;
    core_pkg::word_t     imm_b;
    core_pkg::word_t     imm_u;
    core_pkg::word_t     imm_j;
    core_pkg::word_t     alu_b;
    core_pkg::word_t     alu_result;
    core_pkg::word_t     ls_byte_addr;
    core_pkg::pc_t       pc_plus4;
    logic                writes_rd;
    logic                is_load;
    logic                is_store;

    // ------------------------------
    // fields and immediates
    assign opcode     = rv_isa_pkg::opcode_t'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rd_addr_o  = instr_i[11:7];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    assign pc_plus4 = pc_i + 'd4;

    // ------------------------------
    // decode, anything unknown falls through as a no-op
    always_comb begin
        alu_op    = rv_isa_pkg::alu_add;
        alu_b     = rs2_data_i;
        writes_rd = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        next_pc_o = pc_plus4;
        rd_data_o = alu_result;
        case (opcode)
            rv_isa_pkg::op_lui: begin
                alu_op    = rv_isa_pkg::alu_pass_b;
                alu_b     = imm_u;
                writes_rd = 1'b1;
            end
            rv_isa_pkg::op_imm: begin
                alu_b     = imm_i;
                writes_rd = (funct3 == rv_isa_pkg::f3_add_sub);
            end
            rv_isa_pkg::op_reg: begin
                writes_rd = (funct7 == 7'b0000000);
                case (funct3)
                    rv_isa_pkg::f3_add_sub: begin
                        if (funct7 == 7'b0100000) begin
                            alu_op    = rv_isa_pkg::alu_sub;
                            writes_rd = 1'b1;
                        end
                    end
                    rv_isa_pkg::f3_xor: alu_op = rv_isa_pkg::alu_xor;
                    rv_isa_pkg::f3_or:  alu_op = rv_isa_pkg::alu_or;
                    rv_isa_pkg::f3_and: alu_op = rv_isa_pkg::alu_and;
                    default:            writes_rd = 1'b0;
                endcase
            end
            rv_isa_pkg::op_load:  is_load  = (funct3 == rv_isa_pkg::f3_word);
            rv_isa_pkg::op_store: is_store = (funct3 == rv_isa_pkg::f3_word);
            rv_isa_pkg::op_branch: begin
                // beq and bne only, bit 0 inverts the compare
                if (funct3[2:1] == 2'b00 && ((rs1_data_i == rs2_data_i) ^ funct3[0])) begin
                    next_pc_o = pc_i + imm_b[`PC_BITWIDTH-1:0];
                end
            end
            rv_isa_pkg::op_jal: begin
                writes_rd = 1'b1;
                rd_data_o = core_pkg::word_t'(pc_plus4);
                next_pc_o = pc_i + imm_j[`PC_BITWIDTH-1:0];
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_isa_pkg::alu_sub:    alu_result = rs1_data_i - alu_b;
            rv_isa_pkg::alu_and:    alu_result = rs1_data_i & alu_b;
            rv_isa_pkg::alu_or:     alu_result = rs1_data_i | alu_b;
            rv_isa_pkg::alu_xor:    alu_result = rs1_data_i ^ alu_b;
            rv_isa_pkg::alu_pass_b: alu_result = alu_b;
            default:                alu_result = rs1_data_i + alu_b;
        endcase
    end

    // byte address down to word address
    assign ls_byte_addr = rs1_data_i + (is_store ? imm_s : imm_i);
    assign ls_addr_o    = ls_byte_addr[`MEM_ADDR_BITS+1:2];
    assign store_data_o = rs2_data_i;

    assign rd_we_o = exec_valid_i & writes_rd;
    assign load_o  = exec_valid_i & is_load;
    assign store_o = exec_valid_i & is_store;
    assign halt_o  = exec_valid_i & (instr_i == rv_isa_pkg::ebreak_word);

endmodule

//--- source/load_store_unit.sv
// load/store unit: data requests and load write-back
`timescale 1ns/1ns

module load_store_unit (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                load_i,
    input  logic                store_i,
    input  core_pkg::mem_addr_t addr_i,
    input  core_pkg::word_t     store_data_i,
    input  core_pkg::reg_addr_t rd_addr_i,
    input  logic                data_gnt_i,
    input  logic                data_rvalid_i,
    input  core_pkg::word_t     rdata_i,
    output logic                data_req_o,
    output logic                data_we_o,
    output core_pkg::mem_addr_t data_addr_o,
    output core_pkg::word_t     data_wdata_o,
    output logic                load_we_o,
    output core_pkg::reg_addr_t load_waddr_o,
    output core_pkg::word_t     load_wdata_o,
    output logic                done_o
);

    logic                req_q;
    logic                wait_q;
    logic                we_q;
    core_pkg::reg_addr_t rd_q;

    // request stays up until granted
    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
        end else if (load_i || store_i) begin
            req_q <= 1'b1;
        end else if (req_q && data_gnt_i) begin
            req_q  <= 1'b0;
            wait_q <= ~we_q;
        end else if (wait_q && data_rvalid_i) begin
            wait_q <= 1'b0;
        end
    end

    // access payload
    always_ff @(posedge clk) begin
        if (load_i || store_i) begin
            we_q         <= store_i;
            data_addr_o  <= addr_i;
            data_wdata_o <= store_data_i;
            rd_q         <= rd_addr_i;
        end
    end

    assign data_req_o   = req_q;
    assign data_we_o    = req_q & we_q;
    assign load_we_o    = wait_q & data_rvalid_i;
    assign load_waddr_o = rd_q;
    assign load_wdata_o = rdata_i;
    assign done_o       = (req_q & data_gnt_i & we_q) | load_we_o;

endmodule

//--- source/mem_arbiter.sv
// fixed-priority arbiter for the single word memory port
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                ocd_re_i,
    input  logic                ocd_we_i,
    input  core_pkg::mem_addr_t ocd_addr_i,
    input  core_pkg::word_t     ocd_wdata_i,
    input  logic                data_req_i,
    input  logic                data_we_i,
    input  core_pkg::mem_addr_t data_addr_i,
    input  core_pkg::word_t     data_wdata_i,
    input  logic                fetch_req_i,
    input  core_pkg::mem_addr_t fetch_addr_i,
    output logic                data_gnt_o,
    output logic                fetch_gnt_o,
    output logic                ocd_rvalid_o,
    output logic                data_rvalid_o,
    output logic                fetch_rvalid_o,
    output logic                mem_en_o,
    output logic                mem_we_o,
    output core_pkg::mem_addr_t mem_addr_o,
    output core_pkg::word_t     mem_wdata_o
);

    logic               ocd_active;
    core_pkg::mem_src_t src_d;
    core_pkg::mem_src_t src_q;

    // debugger first, then data, then fetch
    assign ocd_active  = ocd_re_i | ocd_we_i;
    assign data_gnt_o  = data_req_i & ~ocd_active;
    assign fetch_gnt_o = fetch_req_i & ~ocd_active & ~data_req_i;
    assign mem_en_o    = ocd_active | data_req_i | fetch_req_i;

    always_comb begin
        src_d       = core_pkg::src_none;
        mem_we_o    = 1'b0;
        mem_addr_o  = fetch_addr_i;
        mem_wdata_o = data_wdata_i;
        if (ocd_active) begin
            mem_we_o    = ocd_we_i;
            mem_addr_o  = ocd_addr_i;
            mem_wdata_o = ocd_wdata_i;
            if (!ocd_we_i) begin
                src_d = core_pkg::src_ocd;
            end
        end else if (data_req_i) begin
            mem_we_o   = data_we_i;
            mem_addr_o = data_addr_i;
            if (!data_we_i) begin
                src_d = core_pkg::src_data;
            end
        end else if (fetch_req_i) begin
            src_d = core_pkg::src_fetch;
        end
    end

    // read owner, one cycle behind the grant
    always_ff @(posedge clk) begin
        if (reset_i) begin
            src_q <= core_pkg::src_none;
        end else begin
            src_q <= src_d;
        end
    end

    assign ocd_rvalid_o   = (src_q == core_pkg::src_ocd);
    assign data_rvalid_o  = (src_q == core_pkg::src_data);
    assign fetch_rvalid_o = (src_q == core_pkg::src_fetch);

endmodule

//--- source/pipeline_controller.sv
// controller FSM: pc, instruction register, fetch, start and halt
`timescale 1ns/1ns
`include "reindeer_config.svh"

module pipeline_controller (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  core_pkg::pc_t       start_address_i,
    input  logic                fetch_gnt_i,
    input  logic                fetch_rvalid_i,
    input  core_pkg::word_t     rdata_i,
    output logic                fetch_req_o,
    output core_pkg::mem_addr_t fetch_addr_o,
    input  core_pkg::pc_t       next_pc_i,
    input  logic                load_i,
    input  logic                store_i,
    input  logic                halt_i,
    input  logic                lsu_done_i,
    output logic                exec_valid_o,
    output core_pkg::pc_t       pc_o,
    output core_pkg::word_t     instr_o,
    output logic                paused_o
);

    core_pkg::ctl_state_t state_q;
    core_pkg::pc_t        fetch_pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= core_pkg::st_idle;
            fetch_req_o <= 1'b0;
        end else begin
            if (fetch_req_o && fetch_gnt_i) begin
                fetch_req_o <= 1'b0;
            end
            case (state_q)
                core_pkg::st_idle: begin
                    if (start_i) begin
                        state_q     <= core_pkg::st_fetch;
                        fetch_req_o <= 1'b1;
                    end
                end
                core_pkg::st_fetch: begin
                    if (fetch_rvalid_i) begin
                        state_q <= core_pkg::st_execute;
                    end
                end
                core_pkg::st_execute: begin
                    if (halt_i) begin
                        state_q <= core_pkg::st_idle;
                    end else if (load_i || store_i) begin
                        state_q <= core_pkg::st_memory;
                    end else begin
                        state_q     <= core_pkg::st_fetch;
                        fetch_req_o <= 1'b1;
                    end
                end
                default: begin
                    if (lsu_done_i) begin
                        state_q     <= core_pkg::st_fetch;
                        fetch_req_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    // pc of the held instruction stays put on halt
    always_ff @(posedge clk) begin
        if (state_q == core_pkg::st_idle && start_i) begin
            fetch_pc_q <= start_address_i;
        end else if (state_q == core_pkg::st_execute) begin
            fetch_pc_q <= next_pc_i;
        end
        if (state_q == core_pkg::st_fetch && fetch_rvalid_i) begin
            instr_o <= rdata_i;
            pc_o    <= fetch_pc_q;
        end
    end

    assign fetch_addr_o = fetch_pc_q[`PC_BITWIDTH-1:2];
    assign exec_valid_o = (state_q == core_pkg::st_execute);
    assign paused_o     = (state_q == core_pkg::st_idle);

endmodule

//--- source/reg_file.sv
// register file, x0 tied to zero, alu and load write ports
`timescale 1ns/1ns
`include "reindeer_config.svh"

module reg_file (
    input  logic                clk,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    input  logic                alu_we_i,
    input  core_pkg::reg_addr_t alu_waddr_i,
    input  core_pkg::word_t     alu_wdata_i,
    input  logic                load_we_i,
    input  core_pkg::reg_addr_t load_waddr_i,
    input  core_pkg::word_t     load_wdata_i
);

    core_pkg::word_t regs [2**`REG_ADDR_BITS];

    // the two ports are never active together
    always_ff @(posedge clk) begin
        if (alu_we_i && alu_waddr_i != '0) begin
            regs[alu_waddr_i] <= alu_wdata_i;
        end else if (load_we_i && load_waddr_i != '0) begin
            regs[load_waddr_i] <= load_wdata_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- source/reindeer_core.sv
// core top level: arbiter, memory, register file, execute, lsu and controller
`timescale 1ns/1ns

module reindeer_core (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                ocd_read_enable_i,
    input  logic                ocd_write_enable_i,
    input  core_pkg::mem_addr_t ocd_rw_addr_i,
    input  core_pkg::word_t     ocd_write_word_i,
    output logic                ocd_mem_enable_o,
    output core_pkg::word_t     ocd_mem_word_o,
    input  logic                start_i,
    input  core_pkg::pc_t       start_address_i,
    output logic                processor_paused_o,
    output core_pkg::pc_t       peek_pc_o,
    output core_pkg::word_t     peek_ir_o
);

    // ------------------------------
    // memory port
    logic                mem_en;
    logic                mem_we;
    core_pkg::mem_addr_t mem_addr;
    core_pkg::word_t     mem_wdata;

    // requesters
    logic                data_req;
    logic                data_we;
    core_pkg::mem_addr_t data_addr;
    core_pkg::word_t     data_wdata;
    logic                data_gnt;
    logic                data_rvalid;
    logic                fetch_req;
    core_pkg::mem_addr_t fetch_addr;
    logic                fetch_gnt;
    logic                fetch_rvalid;

    // ------------------------------
    // execute path
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    logic                rd_we;
    core_pkg::reg_addr_t rd_addr;
    core_pkg::word_t     rd_data;
    logic                load_we;
    core_pkg::reg_addr_t load_waddr;
    core_pkg::word_t     load_wdata;
    core_pkg::pc_t       next_pc;
    logic                exec_valid;
    logic                load;
    logic                store;
    logic                halt;
    logic                lsu_done;
    core_pkg::mem_addr_t ls_addr;
    core_pkg::word_t     store_data;

    mem_arbiter u_mem_arbiter (
        .clk            (clk),
        .reset_i        (reset_i),
        .ocd_re_i       (ocd_read_enable_i),
        .ocd_we_i       (ocd_write_enable_i),
        .ocd_addr_i     (ocd_rw_addr_i),
        .ocd_wdata_i    (ocd_write_word_i),
        .data_req_i     (data_req),
        .data_we_i      (data_we),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .data_gnt_o     (data_gnt),
        .fetch_gnt_o    (fetch_gnt),
        .ocd_rvalid_o   (ocd_mem_enable_o),
        .data_rvalid_o  (data_rvalid),
        .fetch_rvalid_o (fetch_rvalid),
        .mem_en_o       (mem_en),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata)
    );

    // read word is shared by all three requesters
    word_memory u_word_memory (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (ocd_mem_word_o)
    );

    reg_file u_reg_file (
        .clk          (clk),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .alu_we_i     (rd_we),
        .alu_waddr_i  (rd_addr),
        .alu_wdata_i  (rd_data),
        .load_we_i    (load_we),
        .load_waddr_i (load_waddr),
        .load_wdata_i (load_wdata)
    );

    decode_execute u_decode_execute (
        .exec_valid_i (exec_valid),
        .instr_i      (peek_ir_o),
        .pc_i         (peek_pc_o),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rd_we_o      (rd_we),
        .rd_addr_o    (rd_addr),
        .rd_data_o    (rd_data),
        .next_pc_o    (next_pc),
        .load_o       (load),
        .store_o      (store),
        .ls_addr_o    (ls_addr),
        .store_data_o (store_data),
        .halt_o       (halt)
    );

    load_store_unit u_load_store_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .load_i        (load),
        .store_i       (store),
        .addr_i        (ls_addr),
        .store_data_i  (store_data),
        .rd_addr_i     (rd_addr),
        .data_gnt_i    (data_gnt),
        .data_rvalid_i (data_rvalid),
        .rdata_i       (ocd_mem_word_o),
        .data_req_o    (data_req),
        .data_we_o     (data_we),
        .data_addr_o   (data_addr),
        .data_wdata_o  (data_wdata),
        .load_we_o     (load_we),
        .load_waddr_o  (load_waddr),
        .load_wdata_o  (load_wdata),
        .done_o        (lsu_done)
    );

    pipeline_controller u_pipeline_controller (
        .clk             (clk),
        .reset_i         (reset_i),
        .start_i         (start_i),
        .start_address_i (start_address_i),
        .fetch_gnt_i     (fetch_gnt),
        .fetch_rvalid_i  (fetch_rvalid),
        .rdata_i         (ocd_mem_word_o),
        .fetch_req_o     (fetch_req),
        .fetch_addr_o    (fetch_addr),
        .next_pc_i       (next_pc),
        .load_i          (load),
        .store_i         (store),
        .halt_i          (halt),
        .lsu_done_i      (lsu_done),
        .exec_valid_o    (exec_valid),
        .pc_o            (peek_pc_o),
        .instr_o         (peek_ir_o),
        .paused_o        (processor_paused_o)
    );

endmodule

//--- source/rv_isa_pkg.sv
// instruction-set types: opcode and alu enums, funct3 codes, ebreak word
package rv_isa_pkg;

    typedef logic [2:0] funct3_t;

    // kept major opcodes
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // funct3 codes in use
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;
    localparam funct3_t f3_word    = 3'b010;

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

endpackage

//--- source/word_memory.sv
// single-port word memory, registered read
`timescale 1ns/1ns
`include "reindeer_config.svh"

module word_memory (
    input  logic                clk,
    input  logic                en_i,
    input  logic                we_i,
    input  core_pkg::mem_addr_t addr_i,
    input  core_pkg::word_t     wdata_i,
    output core_pkg::word_t     rdata_o
);

    core_pkg::word_t mem [2**`MEM_ADDR_BITS];

    // a write leaves the read register alone
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

//--- tb/tb_reindeer_core.sv
// testbench for the core: debugger round trip and a table of programs
`timescale 1ns/1ns

module tb_reindeer_core;

    localparam int ROWS      = 4;
    localparam int MAX_WORDS = 12;
    localparam int LIMIT     = (ROWS + 1) * 400;

    logic                clk;
    logic                reset_i;
    logic                ocd_read_enable_i;
    logic                ocd_write_enable_i;
    core_pkg::mem_addr_t ocd_rw_addr_i;
    core_pkg::word_t     ocd_write_word_i;
    logic                ocd_mem_enable_o;
    core_pkg::word_t     ocd_mem_word_o;
    logic                start_i;
    core_pkg::pc_t       start_address_i;
    logic                processor_paused_o;
    core_pkg::pc_t       peek_pc_o;
    core_pkg::word_t     peek_ir_o;

    // program table, one row per run
    core_pkg::word_t     prog [ROWS][MAX_WORDS];
    int                  prog_len [ROWS];
    core_pkg::pc_t       start_pc [ROWS];
    core_pkg::mem_addr_t preset_addr [ROWS];
    core_pkg::word_t     preset_word [ROWS];
    core_pkg::mem_addr_t result_addr [ROWS];
    core_pkg::word_t     expected [ROWS];
    core_pkg::pc_t       halt_pc [ROWS];

    core_pkg::mem_addr_t rt_addr [16];
    core_pkg::word_t     rt_data [16];
    core_pkg::word_t     got;
    int                  seed = 51920;
    int                  cycle_count = 0;

    reindeer_core u_reindeer_core (
        .clk                (clk),
        .reset_i            (reset_i),
        .ocd_read_enable_i  (ocd_read_enable_i),
        .ocd_write_enable_i (ocd_write_enable_i),
        .ocd_rw_addr_i      (ocd_rw_addr_i),
        .ocd_write_word_i   (ocd_write_word_i),
        .ocd_mem_enable_o   (ocd_mem_enable_o),
        .ocd_mem_word_o     (ocd_mem_word_o),
        .start_i            (start_i),
        .start_address_i    (start_address_i),
        .processor_paused_o (processor_paused_o),
        .peek_pc_o          (peek_pc_o),
        .peek_ir_o          (peek_ir_o)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // reporting
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input core_pkg::word_t g, input core_pkg::word_t e,
                              input string what);
        if (g !== e) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                               $time, what, g, e));
        end
    endtask

    task automatic check_pc(input core_pkg::pc_t g, input core_pkg::pc_t e,
                            input string what);
        if (g !== e) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                               $time, what, g, e));
        end
    endtask

    task automatic check_flag(input logic g, input logic e, input string what);
        if (g !== e) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, got %b, expected %b",
                               $time, what, g, e));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles", LIMIT));
        end
    end

    // ------------------------------
    // RV32I instruction formats
    function automatic core_pkg::word_t i_format(int imm, int rs1, int f3, int rd, int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic core_pkg::word_t r_format(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    // sw only
    function automatic core_pkg::word_t s_format(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t b_format(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic core_pkg::word_t u_format(int imm20, int rd);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic core_pkg::word_t j_format(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic append_instr(input int row, input core_pkg::word_t w);
        prog[row][prog_len[row]] = w;
        prog_len[row] = prog_len[row] + 1;
    endtask

    // ------------------------------
    // table rows with results worked out by the RV32I rules
    task automatic build_table();
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t c;
        core_pkg::word_t d;
        core_pkg::word_t e;
        core_pkg::word_t f;
        for (int r = 0; r < ROWS; r++) begin
            prog_len[r] = 0;
        end

        // arithmetic
        start_pc[0] = 10'h000;
        append_instr(0, u_format(20'h12345, 1));
        append_instr(0, i_format(12'h678, 1, 0, 1, 7'b0010011));
        append_instr(0, i_format(12'h0f0, 0, 0, 2, 7'b0010011));
        append_instr(0, r_format(7'h00, 2, 1, 3'b000, 3));
        append_instr(0, r_format(7'h20, 2, 3, 3'b000, 4));
        append_instr(0, r_format(7'h00, 2, 1, 3'b111, 5));
        append_instr(0, r_format(7'h00, 5, 3, 3'b110, 6));
        append_instr(0, r_format(7'h00, 4, 6, 3'b100, 7));
        append_instr(0, s_format(800, 7, 0));
        append_instr(0, 32'h0010_0073);
        a = 32'h1234_5000 + 32'h678;
        b = 32'h0000_00f0;
        c = a + b;
        d = c - b;
        e = a & b;
        f = c | e;
        preset_addr[0] = 8'd250;
        preset_word[0] = '0;
        result_addr[0] = 8'd200;
        expected[0]    = f ^ d;
        halt_pc[0]     = start_pc[0] + 10'd36;

        // load, add, store
        start_pc[1] = 10'h080;
        append_instr(1, i_format(840, 0, 3'b010, 1, 7'b0000011));
        append_instr(1, i_format(12'h123, 0, 0, 2, 7'b0010011));
        append_instr(1, r_format(7'h00, 2, 1, 3'b000, 3));
        append_instr(1, s_format(844, 3, 0));
        append_instr(1, 32'h0010_0073);
        preset_addr[1] = 8'd210;
        preset_word[1] = $random(seed);
        result_addr[1] = 8'd211;
        expected[1]    = preset_word[1] + 32'h123;
        halt_pc[1]     = start_pc[1] + 10'd16;

        // countdown loop, then a backward jal over a bad store
        start_pc[2] = 10'h100;
        append_instr(2, i_format(5, 0, 0, 1, 7'b0010011));
        append_instr(2, i_format(0, 0, 0, 2, 7'b0010011));
        append_instr(2, r_format(7'h00, 1, 2, 3'b000, 2));
        append_instr(2, i_format(-1, 1, 0, 1, 7'b0010011));
        append_instr(2, b_format(-8, 0, 1, 3'b001));
        append_instr(2, b_format(16, 0, 1, 3'b000));
        append_instr(2, r_format(7'h00, 3, 2, 3'b000, 4));
        append_instr(2, s_format(848, 4, 0));
        append_instr(2, 32'h0010_0073);
        append_instr(2, j_format(-12, 3));
        append_instr(2, s_format(848, 0, 0));
        append_instr(2, 32'h0010_0073);
        preset_addr[2] = 8'd250;
        preset_word[2] = '0;
        result_addr[2] = 8'd212;
        expected[2]    = 32'd15 + core_pkg::word_t'(start_pc[2] + 10'd40);
        halt_pc[2]     = start_pc[2] + 10'd32;

        // writes to x0 are dropped
        start_pc[3] = 10'h180;
        append_instr(3, i_format(123, 0, 0, 0, 7'b0010011));
        append_instr(3, u_format(20'habcde, 0));
        append_instr(3, r_format(7'h00, 2, 1, 3'b000, 0));
        append_instr(3, s_format(856, 0, 0));
        append_instr(3, 32'h0010_0073);
        preset_addr[3] = 8'd214;
        preset_word[3] = $random(seed) | 1;
        result_addr[3] = 8'd214;
        expected[3]    = '0;
        halt_pc[3]     = start_pc[3] + 10'd16;
    endtask

    // ------------------------------
    // debugger port
    task automatic write_word(input core_pkg::mem_addr_t addr, input core_pkg::word_t w);
        @(posedge clk);
        #1;
        ocd_write_enable_i = 1'b1;
        ocd_rw_addr_i      = addr;
        ocd_write_word_i   = w;
        @(posedge clk);
        #1;
        ocd_write_enable_i = 1'b0;
    endtask

    // strobe must come exactly one cycle after the read enable
    task automatic read_word(input core_pkg::mem_addr_t addr, output core_pkg::word_t w);
        @(posedge clk);
        #1;
        ocd_read_enable_i = 1'b1;
        ocd_rw_addr_i     = addr;
        check_flag(ocd_mem_enable_o, 1'b0, "read strobe before the read");
        @(posedge clk);
        #1;
        ocd_read_enable_i = 1'b0;
        check_flag(ocd_mem_enable_o, 1'b1, "read strobe one cycle after the read");
        w = ocd_mem_word_o;
        @(posedge clk);
        #1;
        check_flag(ocd_mem_enable_o, 1'b0, "read strobe two cycles after the read");
    endtask

    task automatic run_program(input int row);
        core_pkg::word_t res;
        for (int i = 0; i < prog_len[row]; i++) begin
            write_word(core_pkg::mem_addr_t'((start_pc[row] >> 2) + i), prog[row][i]);
        end
        write_word(preset_addr[row], preset_word[row]);
        check_flag(processor_paused_o, 1'b1, "paused before start");
        @(posedge clk);
        #1;
        start_i         = 1'b1;
        start_address_i = start_pc[row];
        @(posedge clk);
        #1;
        start_i = 1'b0;
        check_flag(processor_paused_o, 1'b0, "paused cleared after start");
        while (processor_paused_o !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        check_pc(peek_pc_o, halt_pc[row], "halt pc");
        check_word(peek_ir_o, 32'h0010_0073, "halting instruction");
        read_word(result_addr[row], res);
        check_word(res, expected[row], "result word");
    endtask

    initial begin
        clk                = 1'b0;
        reset_i            = 1'b1;
        ocd_read_enable_i  = 1'b0;
        ocd_write_enable_i = 1'b0;
        ocd_rw_addr_i      = '0;
        ocd_write_word_i   = '0;
        start_i            = 1'b0;
        start_address_i    = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_flag(processor_paused_o, 1'b1, "paused after reset");
        check_flag(ocd_mem_enable_o, 1'b0, "read strobe after reset");

        // one address per 16-word block keeps them distinct
        for (int i = 0; i < 16; i++) begin
            rt_addr[i] = core_pkg::mem_addr_t'(i * 16 + ($random(seed) & 15));
            rt_data[i] = $random(seed);
            write_word(rt_addr[i], rt_data[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(rt_addr[i], got);
            check_word(got, rt_data[i], "debugger read back");
        end

        for (int r = 0; r < ROWS; r++) begin
            run_program(r);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
source/rv_isa_pkg.sv
source/core_pkg.sv
source/mem_arbiter.sv
source/word_memory.sv
source/reg_file.sv
source/decode_execute.sv
source/load_store_unit.sv
source/pipeline_controller.sv
source/reindeer_core.sv
tb/tb_reindeer_core.sv
